// File: Bender.yml
package:
  name: gb_glue

sources:
  - logic/gb_glue_pkg.sv
  - logic/host_settings.sv
  - logic/shade_colorizer.sv
  - logic/ff_control.sv
  - logic/scaler_out.sv
  - logic/gb_glue_top.sv
  - target: simulation
    files:
      - dv/clk_gen.sv
      - dv/gb_glue_chk.sv
      - dv/gb_glue_tb.sv

// File: dv/clk_gen.sv
module clk_gen (
    output logic clk_sys
);
    timeunit 1ns;
    timeprecision 1ps;

    // 100 ns period
    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

endmodule

// File: dv/gb_glue_chk.sv
module gb_glue_chk (
    input logic                              clk_sys,
    input logic                              reset,
    input logic                              bridge_wr,
    input logic [gb_glue_pkg::WORD_W-1:0]    bridge_addr,
    input logic [gb_glue_pkg::WORD_W-1:0]    bridge_wr_data,
    input logic                              dl_start,
    input logic [gb_glue_pkg::SLOT_ID_W-1:0] dl_id,
    input logic                              dl_done,
    input gb_glue_pkg::lcd_beat_t            lcd,
    input logic [gb_glue_pkg::WORD_W-1:0]    cont_key,
    input logic [gb_glue_pkg::SAMPLE_W-1:0]  audio_l_in,
    input logic [gb_glue_pkg::SAMPLE_W-1:0]  audio_r_in,
    input logic                              core_reset,
    input logic [gb_glue_pkg::RGB_W-1:0]     video_rgb,
    input logic                              video_de,
    input logic                              video_hs,
    input logic                              video_vs,
    input logic                              fast_forward,
    input logic [gb_glue_pkg::SAMPLE_W-1:0]  audio_l,
    input logic [gb_glue_pkg::SAMPLE_W-1:0]  audio_r
);
    timeunit 1ns;
    timeprecision 1ps;
    import gb_glue_pkg::*;

    logic                 assert_failed = 1'b0;
    settings_t            settings_m;
    logic                 dl_open;
    logic [SLOT_ID_W-1:0] dl_slot;
    logic [PAL_W-1:0]     pal_model;
    logic                 cart_m;
    logic                 btn;
    logic                 btn_prev;
    logic                 released;
    logic                 short_tap;
    logic                 tap_armed;
    logic                 mute;
    int                   press_len;

    // color n counted from the top of the palette
    function automatic logic [RGB_W-1:0] color_of(logic [PAL_W-1:0] pal,
                                                  logic [SHADE_W-1:0] shade);
        return pal[PAL_W - 1 - shade * RGB_W -: RGB_W];
    endfunction

    function automatic logic [7:0] gray_of(logic [RGB_W-1:0] c);
        logic [9:0] sum;
        sum = (c[23:16] >> 2) + (c[23:16] >> 5) + (c[15:8] >> 1) + (c[15:8] >> 4)
            + (c[7:0] >> 4) + (c[7:0] >> 5);
        return sum[7:0];
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reference models

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            settings_m <= '0;
            dl_open    <= 1'b0;
            pal_model  <= PALETTE_RESET;
            btn_prev   <= 1'b0;
            tap_armed  <= 1'b1;
            press_len  <= 0;
        end else begin
            // settings bits from the register map
            if (bridge_wr) begin
                case (bridge_addr)
                    REG_FF_EN:     settings_m.ff_en     <= bridge_wr_data[0];
                    REG_FF_SND_EN: settings_m.ff_snd_en <= bridge_wr_data[0];
                    REG_BORDER_EN: settings_m.border_en <= bridge_wr_data[0];
                    REG_BW_EN:     settings_m.bw_en     <= bridge_wr_data[0];
                    default:       ;
                endcase
            end
            if (dl_start) begin
                dl_open <= 1'b1;
                dl_slot <= dl_id;
            end else if (dl_done) begin
                dl_open <= 1'b0;
            end
            // low byte of each word lands above the high byte
            if (bridge_wr && dl_open && (dl_slot == SLOT_PALETTE)) begin
                pal_model <= {pal_model[PAL_W-17:0], bridge_wr_data[7:0], bridge_wr_data[15:8]};
            end
            btn_prev  <= btn;
            press_len <= btn ? press_len + 1 : 0;
            if (released) begin
                tap_armed <= !(short_tap && tap_armed);
            end
        end
    end

    assign cart_m    = dl_open && (dl_slot == SLOT_CART);
    assign btn       = settings_m.ff_en && cont_key[FF_KEY_BIT] && !dl_open;
    assign released  = btn_prev && !btn;
    assign short_tap = press_len < TAP_LIMIT_CYCLES;
    assign mute      = fast_forward && !settings_m.ff_snd_en;

    //////////////////////////////////////////////////////////////////////
    // assertions

    a_reset_hold: assert property (@(posedge clk_sys) disable iff (reset)
        (bridge_wr && (bridge_addr == REG_RESET))
        |=> core_reset [*RESET_HOLD_CYCLES] ##1 (core_reset == cart_m))
    else begin
        assert_failed = 1'b1;
        $error("mismatch at %0t: core_reset hold length", $time);
    end

    a_cart_reset: assert property (@(posedge clk_sys) disable iff (reset)
        cart_m |-> core_reset)
    else begin
        assert_failed = 1'b1;
        $error("mismatch at %0t: core_reset low during cart download", $time);
    end

    a_de: assert property (@(posedge clk_sys) disable iff (reset)
        video_de == $past(!(lcd.hblank || lcd.vblank), 2))
    else begin
        assert_failed = 1'b1;
        $error("mismatch at %0t: video_de", $time);
    end

    a_color: assert property (@(posedge clk_sys) disable iff (reset)
        (video_de && !settings_m.bw_en)
        |-> video_rgb == color_of($past(pal_model, 2), $past(lcd.shade, 2)))
    else begin
        assert_failed = 1'b1;
        $error("mismatch at %0t: colorized rgb %h", $time, video_rgb);
    end

    a_gray: assert property (@(posedge clk_sys) disable iff (reset)
        (video_de && settings_m.bw_en)
        |-> video_rgb == {3{gray_of(color_of($past(pal_model, 2), $past(lcd.shade, 2)))}})
    else begin
        assert_failed = 1'b1;
        $error("mismatch at %0t: grayscale rgb %h", $time, video_rgb);
    end

    a_border: assert property (@(posedge clk_sys) disable iff (reset)
        !video_de |-> video_rgb == (settings_m.border_en ? RGB_W'(0) : BORDER_BLANK_RGB))
    else begin
        assert_failed = 1'b1;
        $error("mismatch at %0t: border code %h", $time, video_rgb);
    end

    a_vsync: assert property (@(posedge clk_sys) disable iff (reset)
        $rose(lcd.vs) |-> ##2 video_vs ##1 !video_vs)
    else begin
        assert_failed = 1'b1;
        $error("mismatch at %0t: video_vs pulse", $time);
    end

    a_hsync: assert property (@(posedge clk_sys) disable iff (reset)
        $rose(lcd.hs) |-> ##(HS_DELAY_CYCLES + 1) video_hs ##1 !video_hs)
    else begin
        assert_failed = 1'b1;
        $error("mismatch at %0t: video_hs pulse", $time);
    end

    a_tap_latch: assert property (@(posedge clk_sys) disable iff (reset)
        (released && short_tap && tap_armed) |=> fast_forward [*16])
    else begin
        assert_failed = 1'b1;
        $error("mismatch at %0t: fast_forward not latched by tap", $time);
    end

    a_release_drop: assert property (@(posedge clk_sys) disable iff (reset)
        (released && !(short_tap && tap_armed)) |=> !fast_forward)
    else begin
        assert_failed = 1'b1;
        $error("mismatch at %0t: fast_forward still high after release", $time);
    end

    a_audio: assert property (@(posedge clk_sys) disable iff (reset)
        (audio_l == (mute ? SAMPLE_W'(0) : audio_l_in))
        && (audio_r == (mute ? SAMPLE_W'(0) : audio_r_in)))
    else begin
        assert_failed = 1'b1;
        $error("mismatch at %0t: audio %h %h", $time, audio_l, audio_r);
    end

endmodule

// File: dv/gb_glue_tb.sv
module gb_glue_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import gb_glue_pkg::*;

    // stimulus runs about 1200 cycles
    const int max_cycles = 4000;

    logic                 clk_sys;
    logic                 reset;
    logic                 bridge_wr;
    logic [WORD_W-1:0]    bridge_addr;
    logic [WORD_W-1:0]    bridge_wr_data;
    logic                 dl_start;
    logic [SLOT_ID_W-1:0] dl_id;
    logic                 dl_done;
    lcd_beat_t            lcd;
    logic [WORD_W-1:0]    cont_key;
    logic [SAMPLE_W-1:0]  audio_l_in;
    logic [SAMPLE_W-1:0]  audio_r_in;
    logic                 core_reset;
    logic [RGB_W-1:0]     video_rgb;
    logic                 video_de;
    logic                 video_hs;
    logic                 video_vs;
    logic                 fast_forward;
    logic [SAMPLE_W-1:0]  audio_l;
    logic [SAMPLE_W-1:0]  audio_r;
    int                   seed = 28;
    int                   cycles = 0;

    bind gb_glue_top gb_glue_chk i_chk (.*);

    clk_gen i_clk_gen (
        .clk_sys (clk_sys)
    );

    gb_glue_top i_dut (.*);

    //////////////////////////////////////////////////////////////////////
    // drive helpers

    // inputs change 10 ns after the edge, audio is fresh every cycle
    task automatic tick();
        @(posedge clk_sys);
        #10ns;
        audio_l_in = SAMPLE_W'($random(seed));
        audio_r_in = SAMPLE_W'($random(seed));
    endtask

    task automatic host_write(input logic [WORD_W-1:0] addr, input logic [WORD_W-1:0] data);
        bridge_wr      = 1'b1;
        bridge_addr    = addr;
        bridge_wr_data = data;
        tick();
        bridge_wr      = 1'b0;
    endtask

    task automatic download(input slot_id_e slot, input int words);
        dl_start = 1'b1;
        dl_id    = slot;
        tick();
        dl_start = 1'b0;
        for (int i = 0; i < words; i++) begin
            host_write(WORD_W'(32'h1000 + 2 * i), WORD_W'($random(seed)));
        end
        dl_done = 1'b1;
        tick();
        dl_done = 1'b0;
        tick();
    endtask

    // 5 lines of 40 beats, line 0 is vblank
    task automatic run_frame();
        for (int line = 0; line < 5; line++) begin
            for (int x = 0; x < 40; x++) begin
                lcd.hs     = (x < 2);
                lcd.vs     = (line == 0) && (x < 4);
                lcd.hblank = (x < 8);
                lcd.vblank = (line == 0);
                lcd.shade  = SHADE_W'($random(seed));
                tick();
            end
        end
    endtask

    task automatic press_key(input int hold, input int idle);
        cont_key = WORD_W'(1) << FF_KEY_BIT;
        repeat (hold) tick();
        cont_key = '0;
        repeat (idle) tick();
    endtask

    //////////////////////////////////////////////////////////////////////
    // failure and timeout watch

    always @(posedge i_dut.i_chk.assert_failed) begin
        $display("Test FAILED");
        $fatal(1, "an assertion in the checker failed");
    end

    always @(posedge clk_sys) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: stimulus did not finish within %0d cycles", max_cycles);
            $display("Test FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        reset          = 1'b1;
        bridge_wr      = 1'b0;
        bridge_addr    = '0;
        bridge_wr_data = '0;
        dl_start       = 1'b0;
        dl_id          = '0;
        dl_done        = 1'b0;
        lcd            = '{hs: 1'b0, vs: 1'b0, hblank: 1'b1, vblank: 1'b1, shade: '0};
        cont_key       = '0;
        audio_l_in     = '0;
        audio_r_in     = '0;
        repeat (4) tick();
        reset = 1'b0;

        // reset hold, then a cart load and a palette load
        host_write(REG_RESET, 32'd1);
        while (core_reset) tick();
        download(SLOT_CART, 8);
        download(SLOT_PALETTE, 6);

        // one frame per bw and border combination
        for (int mode = 0; mode < 4; mode++) begin
            host_write(REG_BW_EN, WORD_W'(mode % 2));
            host_write(REG_BORDER_EN, WORD_W'(mode / 2));
            run_frame();
        end

        // tap, long hold, then tap twice with sound on
        host_write(REG_FF_EN, 32'd1);
        host_write(REG_FF_SND_EN, 32'd0);
        press_key(5, 40);
        press_key(40, 10);
        host_write(REG_FF_SND_EN, 32'd1);
        press_key(5, 20);
        press_key(5, 20);
        repeat (40) tick();

        if (i_dut.i_chk.assert_failed) begin
            $display("Test FAILED");
            $fatal(1, "an assertion in the checker failed");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// File: filelist.f
logic/gb_glue_pkg.sv
logic/host_settings.sv
logic/shade_colorizer.sv
logic/ff_control.sv
logic/scaler_out.sv
logic/gb_glue_top.sv
dv/clk_gen.sv
dv/gb_glue_chk.sv
dv/gb_glue_tb.sv

// File: logic/ff_control.sv
module ff_control (
    input  logic                                clk_sys,
    input  logic                                reset,
    input  gb_glue_pkg::settings_t              settings,
    input  logic                                dl_active,
    input  logic [gb_glue_pkg::WORD_W-1:0]      cont_key,
    input  logic [gb_glue_pkg::SAMPLE_W-1:0]    audio_l_in,
    input  logic [gb_glue_pkg::SAMPLE_W-1:0]    audio_r_in,
    output logic                                fast_forward,
    output logic [gb_glue_pkg::SAMPLE_W-1:0]    audio_l,
    output logic [gb_glue_pkg::SAMPLE_W-1:0]    audio_r
);
    import gb_glue_pkg::*;

    logic             button;
    logic             last_btn;
    logic [TAP_W-1:0] press_cnt;
    logic             ff_latch;
    logic             ff_was_held;
    logic             latch_next;
    logic             was_held_next;
    logic             mute;

    assign button = settings.ff_en && cont_key[FF_KEY_BIT] && !dl_active;

    // a press clears the latch, a short release sets it unless the last one did
    always_comb begin
        latch_next    = ff_latch;
        was_held_next = ff_was_held;
        if (button && !last_btn) begin
            latch_next = 1'b0;
        end
        if (!button && last_btn) begin
            was_held_next = 1'b0;
            if ((press_cnt < TAP_W'(TAP_LIMIT_CYCLES)) && !ff_was_held) begin
                was_held_next = 1'b1;
                latch_next    = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            last_btn     <= 1'b0;
            press_cnt    <= '0;
            ff_latch     <= 1'b0;
            ff_was_held  <= 1'b0;
            fast_forward <= 1'b0;
        end else begin
            last_btn     <= button;
            ff_latch     <= latch_next;
            ff_was_held  <= was_held_next;
            fast_forward <= button || latch_next;
            // cycles held, saturating at the tap limit
            if (button && !last_btn) begin
                press_cnt <= TAP_W'(1);
            end else if (button && (press_cnt < TAP_W'(TAP_LIMIT_CYCLES))) begin
                press_cnt <= press_cnt + 1'b1;
            end
        end
    end

    assign mute    = fast_forward && !settings.ff_snd_en;
    assign audio_l = mute ? '0 : audio_l_in;
    assign audio_r = mute ? '0 : audio_r_in;

endmodule

// File: logic/gb_glue_pkg.sv
package gb_glue_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths

    localparam int WORD_W    = 32;
    localparam int SAMPLE_W  = 16;
    localparam int RGB_W     = 24;
    localparam int SHADE_W   = 2;
    localparam int SLOT_ID_W = 16;
    localparam int PAL_W     = 4 * RGB_W;

    //////////////////////////////////////////////////////////////////////
    // timing and key constants, scaled for simulation

    localparam int RESET_HOLD_CYCLES = 64;
    localparam int TAP_LIMIT_CYCLES  = 32;
    localparam int HS_DELAY_CYCLES   = 7;
    localparam int FF_KEY_BIT        = 9;

    // counter widths derived from the limits above
    localparam int HOLD_W   = $clog2(RESET_HOLD_CYCLES + 1);
    localparam int TAP_W    = $clog2(TAP_LIMIT_CYCLES + 1);
    localparam int HS_CNT_W = $clog2(HS_DELAY_CYCLES);

    // scaler border code, only bit 13 set
    localparam logic [RGB_W-1:0] BORDER_BLANK_RGB = 24'h00_2000;

    // four colors, color 0 in the top 24 bits
    localparam logic [PAL_W-1:0] PALETTE_RESET = 96'h828214_517356_305A5F_1A3B49;

    //////////////////////////////////////////////////////////////////////
    // bridge register offsets and download slots

    typedef enum logic [WORD_W-1:0] {
        REG_RESET     = 32'h0000_0050,
        REG_FF_EN     = 32'h0000_020C,
        REG_FF_SND_EN = 32'h0000_0210,
        REG_BORDER_EN = 32'h0000_0218,
        REG_BW_EN     = 32'h0000_0220
    } host_reg_e;

    typedef enum logic [SLOT_ID_W-1:0] {
        SLOT_CART    = 16'd1,
        SLOT_BORDER  = 16'd2,
        SLOT_PALETTE = 16'd3
    } slot_id_e;

    typedef struct packed {
        logic ff_en;
        logic ff_snd_en;
        logic border_en;
        logic bw_en;
    } settings_t;

    typedef struct packed {
        logic               hs;
        logic               vs;
        logic               hblank;
        logic               vblank;
        logic [SHADE_W-1:0] shade;
    } lcd_beat_t;

    typedef struct packed {
        logic             hs;
        logic             vs;
        logic             de;
        logic [RGB_W-1:0] rgb;
    } pix_beat_t;

endpackage

// File: logic/gb_glue_top.sv
module gb_glue_top (
    input  logic                                clk_sys,
    input  logic                                reset,
    input  logic                                bridge_wr,
    input  logic [gb_glue_pkg::WORD_W-1:0]      bridge_addr,
    input  logic [gb_glue_pkg::WORD_W-1:0]      bridge_wr_data,
    input  logic                                dl_start,
    input  logic [gb_glue_pkg::SLOT_ID_W-1:0]   dl_id,
    input  logic                                dl_done,
    input  gb_glue_pkg::lcd_beat_t              lcd,
    input  logic [gb_glue_pkg::WORD_W-1:0]      cont_key,
    input  logic [gb_glue_pkg::SAMPLE_W-1:0]    audio_l_in,
    input  logic [gb_glue_pkg::SAMPLE_W-1:0]    audio_r_in,
    output logic                                core_reset,
    output logic [gb_glue_pkg::RGB_W-1:0]       video_rgb,
    output logic                                video_de,
    output logic                                video_hs,
    output logic                                video_vs,
    output logic                                fast_forward,
    output logic [gb_glue_pkg::SAMPLE_W-1:0]    audio_l,
    output logic [gb_glue_pkg::SAMPLE_W-1:0]    audio_r
);
    import gb_glue_pkg::*;

    settings_t           settings;
    pix_beat_t           pix;
    logic                dl_active;
    logic                pal_wr;
    logic [SAMPLE_W-1:0] pal_word;

    host_settings i_host_settings (
        .clk_sys        (clk_sys),
        .reset          (reset),
        .bridge_wr      (bridge_wr),
        .bridge_addr    (bridge_addr),
        .bridge_wr_data (bridge_wr_data),
        .dl_start       (dl_start),
        .dl_done        (dl_done),
        .dl_id          (dl_id),
        .settings       (settings),
        .dl_active      (dl_active),
        .pal_wr         (pal_wr),
        .pal_word       (pal_word),
        .core_reset     (core_reset)
    );

    shade_colorizer i_shade_colorizer (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .pal_wr   (pal_wr),
        .pal_word (pal_word),
        .lcd      (lcd),
        .pix      (pix)
    );

    ff_control i_ff_control (
        .clk_sys      (clk_sys),
        .reset        (reset),
        .settings     (settings),
        .dl_active    (dl_active),
        .cont_key     (cont_key),
        .audio_l_in   (audio_l_in),
        .audio_r_in   (audio_r_in),
        .fast_forward (fast_forward),
        .audio_l      (audio_l),
        .audio_r      (audio_r)
    );

    scaler_out i_scaler_out (
        .clk_sys   (clk_sys),
        .reset     (reset),
        .settings  (settings),
        .pix       (pix),
        .video_rgb (video_rgb),
        .video_de  (video_de),
        .video_hs  (video_hs),
        .video_vs  (video_vs)
    );

endmodule

// File: logic/host_settings.sv
module host_settings (
    input  logic                                clk_sys,
    input  logic                                reset,
    input  logic                                bridge_wr,
    input  logic [gb_glue_pkg::WORD_W-1:0]      bridge_addr,
    input  logic [gb_glue_pkg::WORD_W-1:0]      bridge_wr_data,
    input  logic                                dl_start,
    input  logic                                dl_done,
    input  logic [gb_glue_pkg::SLOT_ID_W-1:0]   dl_id,
    output gb_glue_pkg::settings_t              settings,
    output logic                                dl_active,
    output logic                                pal_wr,
    output logic [gb_glue_pkg::SAMPLE_W-1:0]    pal_word,
    output logic                                core_reset
);
    import gb_glue_pkg::*;

    logic [HOLD_W-1:0]    hold_cnt;
    logic [SLOT_ID_W-1:0] dl_slot;
    logic                 cart_dl;

    // register bank and reset-hold counter
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            settings <= '0;
            hold_cnt <= HOLD_W'(RESET_HOLD_CYCLES);
        end else begin
            if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
            if (bridge_wr) begin
                case (bridge_addr)
                    REG_RESET:     hold_cnt           <= HOLD_W'(RESET_HOLD_CYCLES);
                    REG_FF_EN:     settings.ff_en     <= bridge_wr_data[0];
                    REG_FF_SND_EN: settings.ff_snd_en <= bridge_wr_data[0];
                    REG_BORDER_EN: settings.border_en <= bridge_wr_data[0];
                    REG_BW_EN:     settings.bw_en     <= bridge_wr_data[0];
                    default:       ;
                endcase
            end
        end
    end

    // download window, start wins over done
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            dl_active <= 1'b0;
        end else if (dl_start) begin
            dl_active <= 1'b1;
        end else if (dl_done) begin
            dl_active <= 1'b0;
        end
    end

    // slot id of the current download
    always_ff @(posedge clk_sys) begin
        if (dl_start) begin
            dl_slot <= dl_id;
        end
    end

    assign cart_dl  = dl_active && (dl_slot == SLOT_CART);
    assign pal_wr   = bridge_wr && dl_active && (dl_slot == SLOT_PALETTE);
    assign pal_word = bridge_wr_data[SAMPLE_W-1:0];

    // core held in reset for the hold time or a cart load
    assign core_reset = (hold_cnt != '0) || cart_dl;

endmodule

// File: logic/scaler_out.sv
module scaler_out (
    input  logic                                clk_sys,
    input  logic                                reset,
    input  gb_glue_pkg::settings_t              settings,
    input  gb_glue_pkg::pix_beat_t              pix,
    output logic [gb_glue_pkg::RGB_W-1:0]       video_rgb,
    output logic                                video_de,
    output logic                                video_hs,
    output logic                                video_vs
);
    import gb_glue_pkg::*;

    logic [RGB_W-1:0]    rgb_q;
    logic                de_q;
    logic                hs_prev;
    logic                vs_prev;
    logic [HS_CNT_W-1:0] hs_cnt;
    logic [7:0]          lum;

    //////////////////////////////////////////////////////////////////////
    // sync shaping

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            de_q     <= 1'b0;
            hs_prev  <= 1'b0;
            vs_prev  <= 1'b0;
            hs_cnt   <= '0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
        end else begin
            de_q     <= pix.de;
            hs_prev  <= pix.hs;
            vs_prev  <= pix.vs;
            video_vs <= pix.vs && !vs_prev;
            // hsync moved away from vsync so the two never overlap
            if (pix.hs && !hs_prev) begin
                hs_cnt <= HS_CNT_W'(HS_DELAY_CYCLES - 1);
            end else if (hs_cnt != '0) begin
                hs_cnt <= hs_cnt - 1'b1;
            end
            video_hs <= (hs_cnt == HS_CNT_W'(1));
        end
    end

    always_ff @(posedge clk_sys) begin
        rgb_q <= pix.rgb;
    end

    //////////////////////////////////////////////////////////////////////
    // color output

    // approx 0.28 R + 0.56 G + 0.09 B
    assign lum = (rgb_q[23:16] >> 2) + (rgb_q[23:16] >> 5)
               + (rgb_q[15:8] >> 1) + (rgb_q[15:8] >> 4)
               + (rgb_q[7:0] >> 4) + (rgb_q[7:0] >> 5);

    always_comb begin
        if (!de_q) begin
            video_rgb = settings.border_en ? '0 : BORDER_BLANK_RGB;
        end else if (settings.bw_en) begin
            video_rgb = {lum, lum, lum};
        end else begin
            video_rgb = rgb_q;
        end
    end

    assign video_de = de_q;

endmodule

// File: logic/shade_colorizer.sv
module shade_colorizer (
    input  logic                                clk_sys,
    input  logic                                reset,
    input  logic                                pal_wr,
    input  logic [gb_glue_pkg::SAMPLE_W-1:0]    pal_word,
    input  gb_glue_pkg::lcd_beat_t              lcd,
    output gb_glue_pkg::pix_beat_t              pix
);
    import gb_glue_pkg::*;

    logic [PAL_W-1:0]         palette;
    logic [3:0][RGB_W-1:0]    pal_colors;

    // palette shift register, low byte of each word goes in first
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            palette <= PALETTE_RESET;
        end else if (pal_wr) begin
            palette <= {palette[PAL_W-SAMPLE_W-1:0], pal_word[7:0], pal_word[15:8]};
        end
    end

    // color 0 sits in the top slot
    assign pal_colors = palette;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pix.hs <= 1'b0;
            pix.vs <= 1'b0;
            pix.de <= 1'b0;
        end else begin
            pix.hs <= lcd.hs;
            pix.vs <= lcd.vs;
            pix.de <= !(lcd.hblank || lcd.vblank);
        end
    end

    // shade n picks slot 3-n
    always_ff @(posedge clk_sys) begin
        pix.rgb <= pal_colors[~lcd.shade];
    end

endmodule
